// File: debug_top.f
source/debug_pkg.sv
source/baud_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/byte_fifo.sv
source/debug_unit.sv
source/instr_mem.sv
source/debug_top.sv
bench/debug_top_chk.sv
bench/debug_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= debug_top_tb
FILELIST  ?= debug_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/debug_top_tb.sv
`timescale 1ns/1ps

module debug_top_tb;
    import debug_pkg::*;

    localparam int BIT_CYCLES    = TICK_DIV * OVERSAMPLING;
    localparam int BAD_STOP_LOW  = 12 * TICK_DIV;   // Past the stop sample, short of a new start
    localparam int RX_TIMEOUT    = 64 * BIT_CYCLES; // Covers a full command still being sent
    localparam int IDLE_CYCLES   = 2 * BIT_CYCLES;  // Longer than any gap inside a reply
    localparam int DRAIN_TIMEOUT = 1000 * BIT_CYCLES;
    localparam int FLOOD_CMDS    = 40;

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_rx;
    logic                  o_tx;
    logic                  o_overflow;
    logic [NB_ADDR-1:0]    o_load_count;

    logic [NB_DATA_32-1:0] model_mem [MEM_DEPTH]; // Host view of the instruction memory
    logic [NB_ADDR-1:0]    model_ptr;
    int                    seed;
    int                    err_count;
    int                    test_errs;
    int                    tests_passed;
    int                    tests_failed;
    bit                    timed_out;
    string                 test_name;
    int                    i;

    debug_top u_dut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rx         (i_rx),
        .o_tx         (o_tx),
        .o_overflow   (o_overflow),
        .o_load_count (o_load_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            err_count++;
        end
    endtask

    // Drives one line level for a number of clock cycles
    task automatic hold_line(input logic level, input int cycles);
        @(posedge clk);
        #1;
        i_rx = level;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data, input bit bad_stop);
        int b;
        hold_line(1'b0, BIT_CYCLES); // Start bit
        for (b = 0; b < NB_DATA_8; b++) begin
            hold_line(data[b], BIT_CYCLES);
        end
        if (bad_stop) begin
            hold_line(1'b0, BAD_STOP_LOW);
            hold_line(1'b1, BIT_CYCLES - BAD_STOP_LOW);
        end else begin
            hold_line(1'b1, BIT_CYCLES);
        end
    endtask

    // Returns at the middle of the stop bit
    task automatic recv_byte(output logic [7:0] data);
        int waited;
        int b;
        waited = 0;
        data   = 'x;
        while (o_tx !== 1'b0 && waited < RX_TIMEOUT && !timed_out) begin
            @(negedge clk);
            waited++;
        end
        if (o_tx !== 1'b0) begin
            if (!timed_out) begin
                $display("Timeout: no reply byte appeared on o_tx in test %s", test_name);
            end
            timed_out = 1'b1;
        end else begin
            repeat (BIT_CYCLES / 2) @(negedge clk);
            check_value("start bit", 32'd0, 32'(o_tx));
            for (b = 0; b < NB_DATA_8; b++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                data[b] = o_tx; // LSB first
            end
            repeat (BIT_CYCLES) @(negedge clk);
            check_value("stop bit", 32'd1, 32'(o_tx));
        end
    endtask

    // Command bytes MSB first in cmd_bytes, reply collected while sending
    task automatic exchange(input logic [39:0] cmd_bytes, input int n_cmd, input bit bad_stop,
                            input int n_reply, output logic [31:0] reply);
        logic [7:0] rx_data;
        int         c;
        int         r;
        reply = '0;
        fork
            begin
                for (c = 0; c < n_cmd; c++) begin
                    send_byte(cmd_bytes[39 - 8 * c -: 8], bad_stop && (c == 0));
                end
            end
            begin
                for (r = 0; r < n_reply; r++) begin
                    recv_byte(rx_data);
                    reply = {reply[23:0], rx_data};
                end
            end
        join
    endtask

    task automatic load_word(input logic [31:0] word);
        logic [31:0] reply;
        exchange({CMD_LOAD, word}, 5, 1'b0, 1, reply);
        check_value("load reply", 32'(RSP_ACK), reply);
        model_mem[model_ptr] = word;
        model_ptr = model_ptr + 1'b1; // Wraps at 32
    endtask

    task automatic read_word(input logic [7:0] addr_byte);
        logic [31:0] reply;
        exchange({CMD_READ, addr_byte, 24'd0}, 2, 1'b0, 4, reply);
        check_value($sformatf("word %0d", addr_byte[NB_ADDR-1:0]),
                    model_mem[addr_byte[NB_ADDR-1:0]], reply);
    endtask

    task automatic send_single(input logic [7:0] cmd, input bit bad_stop,
                               input logic [7:0] expected);
        logic [31:0] reply;
        exchange({cmd, 32'd0}, 1, bad_stop, 1, reply);
        check_value($sformatf("reply to 0x%02h", cmd), 32'(expected), reply);
    endtask

    // Reads are sent back to back, replies are left unread
    task automatic flood_reads();
        int n;
        for (n = 0; n < FLOOD_CMDS; n++) begin
            send_byte(CMD_READ, 1'b0);
            send_byte(8'(n % 8), 1'b0);
        end
    endtask

    task automatic wait_tx_idle();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < IDLE_CYCLES && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
            quiet = (o_tx === 1'b1) ? quiet + 1 : 0;
        end
        if (quiet < IDLE_CYCLES) begin
            $display("Timeout: o_tx did not return to idle after the command flood");
            timed_out = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_errs && !timed_out) begin
            tests_passed++;
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s", test_name);
        end
    endtask

    initial begin
        i_rst_n      = 1'b1;
        i_rx         = 1'b1; // Idle line
        seed         = 42753;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        model_ptr    = '0;
        #1;
        i_rst_n = 1'b0; // First clock edge already sees reset asserted
        repeat (5) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        check_value("o_tx", 32'd1, 32'(o_tx));
        check_value("o_load_count", 32'd0, 32'(o_load_count));
        check_value("o_overflow", 32'd0, 32'(o_overflow));
        end_test();

        if (!timed_out) begin
            begin_test("load_words");
            for (i = 0; i < 8; i++) begin
                load_word(32'($random(seed)));
            end
            check_value("o_load_count", 32'd8, 32'(o_load_count));
            end_test();
        end

        if (!timed_out) begin
            begin_test("read_words");
            for (i = 0; i < 8; i++) begin
                read_word((i % 2 == 1) ? 8'(8'hA0 | i) : 8'(i)); // Upper bits ignored
            end
            end_test();
        end

        if (!timed_out) begin
            begin_test("clear_and_reload");
            send_single(CMD_CLEAR, 1'b0, RSP_ACK);
            model_ptr = '0;
            check_value("o_load_count", 32'd0, 32'(o_load_count));
            load_word(32'($random(seed)));
            load_word(32'($random(seed)));
            for (i = 0; i < 8; i++) begin
                read_word(8'(i));
            end
            end_test();
        end

        if (!timed_out) begin
            begin_test("bad_commands");
            send_single(8'h5A, 1'b0, RSP_NAK);
            send_single(CMD_LOAD, 1'b1, RSP_NAK); // Framing error on the command byte
            read_word(8'h03);
            check_value("o_load_count", 32'(model_ptr), 32'(o_load_count));
            end_test();
        end

        if (!timed_out) begin
            begin_test("fifo_overflow");
            flood_reads();
            check_value("o_overflow after flood", 32'd1, 32'(o_overflow));
            wait_tx_idle();
            check_value("o_overflow after drain", 32'd1, 32'(o_overflow));
            check_value("o_load_count", 32'(model_ptr), 32'(o_load_count));
            end_test();
        end

        begin_test("bound_assertions");
        check_value("assertion failures", 32'd0, 32'(u_dut.u_chk.fail_count));
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bench/debug_top_chk.sv
`timescale 1ns/1ps

module debug_top_chk (
    input logic                          i_clk,
    input logic                          i_rst_n,
    input logic                          i_tx,
    input logic                          i_overflow,
    input logic [debug_pkg::NB_ADDR-1:0] i_load_count
);
    int fail_count = 0; // Read by the testbench at the end of the run

    tx_idle_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> i_tx)
        else begin
            fail_count++;
            $error("o_tx left the idle level while reset is asserted");
        end

    overflow_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_overflow |=> i_overflow)
        else begin
            fail_count++;
            $error("o_overflow fell after it had risen");
        end

    // Load pointer only steps forward or clears
    load_count_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $stable(i_load_count) || (i_load_count == '0) ||
        (i_load_count == $past(i_load_count) + 5'd1))
        else begin
            fail_count++;
            $error("o_load_count changed by something other than +1 or a clear");
        end

endmodule

bind debug_top debug_top_chk u_chk (
    .i_clk        (clk),
    .i_rst_n      (i_rst_n),
    .i_tx         (o_tx),
    .i_overflow   (o_overflow),
    .i_load_count (o_load_count)
);

// File: source/debug_top.sv
`timescale 1ns/1ps

module debug_top (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_rx,
    output logic                          o_tx,
    output logic                          o_overflow,
    output logic [debug_pkg::NB_ADDR-1:0] o_load_count
);
    import debug_pkg::*;

    logic                  tick;
    rx_byte_t              rx_byte;
    logic                  rx_valid;
    rx_byte_t              fifo_head;
    logic                  fifo_empty;
    logic                  pop;
    logic                  wr_en;
    mem_wr_t               wr;
    logic [NB_ADDR-1:0]    rd_addr;
    logic [NB_DATA_32-1:0] rd_data;
    logic                  tx_start;
    logic [NB_DATA_8-1:0]  tx_data;
    logic                  tx_done;

    baud_gen u_baud_gen (
        .i_clk   (clk),
        .i_rst_n (i_rst_n),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clk   (clk),
        .i_rst_n (i_rst_n),
        .i_rx    (i_rx),
        .i_tick  (tick),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    byte_fifo u_byte_fifo (
        .i_clk      (clk),
        .i_rst_n    (i_rst_n),
        .i_push     (rx_valid),
        .i_pop      (pop),
        .i_byte     (rx_byte),
        .o_head     (fifo_head),
        .o_empty    (fifo_empty),
        .o_overflow (o_overflow)
    );

    debug_unit u_debug_unit (
        .i_clk        (clk),
        .i_rst_n      (i_rst_n),
        .i_head       (fifo_head),
        .i_empty      (fifo_empty),
        .i_tx_done    (tx_done),
        .i_rd_data    (rd_data),
        .o_pop        (pop),
        .o_wr_en      (wr_en),
        .o_tx_start   (tx_start),
        .o_wr         (wr),
        .o_rd_addr    (rd_addr),
        .o_tx_data    (tx_data),
        .o_load_count (o_load_count)
    );

    instr_mem u_instr_mem (
        .i_clk     (clk),
        .i_wr_en   (wr_en),
        .i_wr      (wr),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    uart_tx u_uart_tx (
        .i_clk   (clk),
        .i_rst_n (i_rst_n),
        .i_tick  (tick),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_tx),
        .o_done  (tx_done)
    );

endmodule

// File: source/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic                             i_clk,
    input  logic                             i_wr_en,
    input  debug_pkg::mem_wr_t               i_wr,
    input  logic [debug_pkg::NB_ADDR-1:0]    i_rd_addr,
    output logic [debug_pkg::NB_DATA_32-1:0] o_rd_data
);
    import debug_pkg::*;

    logic [NB_DATA_32-1:0] mem [MEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
        o_rd_data <= mem[i_rd_addr]; // One-cycle read
    end

endmodule

// File: source/debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  debug_pkg::rx_byte_t              i_head,
    input  logic                             i_empty,
    input  logic                             i_tx_done,
    input  logic [debug_pkg::NB_DATA_32-1:0] i_rd_data,
    output logic                             o_pop,
    output logic                             o_wr_en,
    output logic                             o_tx_start,
    output debug_pkg::mem_wr_t               o_wr,
    output logic [debug_pkg::NB_ADDR-1:0]    o_rd_addr,
    output logic [debug_pkg::NB_DATA_8-1:0]  o_tx_data,
    output logic [debug_pkg::NB_ADDR-1:0]    o_load_count
);
    import debug_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GET_ARGS,
        WRITE,
        READ,
        SEND,
        WAIT_DONE
    } state_t;

    state_t                state;
    logic [NB_DATA_8-1:0]  cmd;
    logic [2:0]            arg_cnt;  // Argument bytes still expected
    logic [2:0]            byte_cnt; // Reply bytes still to send
    logic [NB_ADDR-1:0]    load_ptr;
    logic [NB_DATA_32-1:0] word;
    logic [NB_DATA_32-1:0] rsp_word; // Reply bytes, next one on top
    logic                  take;

    assign take = !i_empty && (state == IDLE || state == GET_ARGS);

    assign o_pop        = take;
    assign o_wr_en      = (state == WRITE);
    assign o_wr.addr    = load_ptr;
    assign o_wr.data    = word;
    assign o_rd_addr    = i_head.data[NB_ADDR-1:0]; // Sampled by memory on the address pop
    assign o_tx_start   = (state == SEND);
    assign o_tx_data    = rsp_word[NB_DATA_32-1 -: NB_DATA_8];
    assign o_load_count = load_ptr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            arg_cnt  <= '0;
            byte_cnt <= '0;
            load_ptr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        byte_cnt <= 3'd1;
                        state    <= SEND; // NAK unless a known command
                        if (!i_head.frame_err) begin
                            case (i_head.data)
                                CMD_LOAD: begin
                                    arg_cnt <= 3'd4;
                                    state   <= GET_ARGS;
                                end
                                CMD_READ: begin
                                    arg_cnt <= 3'd1;
                                    state   <= GET_ARGS;
                                end
                                CMD_CLEAR: load_ptr <= '0;
                                default: ;
                            endcase
                        end
                    end
                end
                GET_ARGS: begin
                    if (take) begin
                        arg_cnt <= arg_cnt - 1'b1;
                        if (i_head.frame_err) begin
                            byte_cnt <= 3'd1;
                            state    <= SEND; // Abort with NAK
                        end else if (arg_cnt == 3'd1) begin
                            state <= (cmd == CMD_LOAD) ? WRITE : READ;
                        end
                    end
                end
                WRITE: begin
                    load_ptr <= load_ptr + 1'b1; // Wraps at 32
                    byte_cnt <= 3'd1;
                    state    <= SEND;
                end
                READ: begin
                    byte_cnt <= 3'd4;
                    state    <= SEND;
                end
                SEND: state <= WAIT_DONE;
                WAIT_DONE: begin
                    if (i_tx_done) begin
                        byte_cnt <= byte_cnt - 1'b1;
                        state    <= (byte_cnt == 3'd1) ? IDLE : SEND;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                if (take) begin
                    cmd <= i_head.data;
                    if (!i_head.frame_err && i_head.data == CMD_CLEAR) begin
                        rsp_word <= {RSP_ACK, 24'd0};
                    end else begin
                        rsp_word <= {RSP_NAK, 24'd0};
                    end
                end
            end
            GET_ARGS: begin
                if (take) begin
                    word     <= {word[NB_DATA_32-NB_DATA_8-1:0], i_head.data}; // MSB first
                    rsp_word <= {RSP_NAK, 24'd0};
                end
            end
            WRITE:     rsp_word <= {RSP_ACK, 24'd0};
            READ:      rsp_word <= i_rd_data;
            WAIT_DONE: begin
                if (i_tx_done) begin
                    rsp_word <= rsp_word << NB_DATA_8;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_push,
    input  logic                i_pop,
    input  debug_pkg::rx_byte_t i_byte,
    output debug_pkg::rx_byte_t o_head,
    output logic                o_empty,
    output logic                o_overflow
);
    import debug_pkg::*;

    rx_byte_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_NB:0]   wr_ptr; // MSB is the wrap bit
    logic [FIFO_PTR_NB:0]   rd_ptr;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign o_empty = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[FIFO_PTR_NB] != rd_ptr[FIFO_PTR_NB]) &&
                     (wr_ptr[FIFO_PTR_NB-1:0] == rd_ptr[FIFO_PTR_NB-1:0]);
    assign do_push = i_push && !full;
    assign do_pop  = i_pop && !o_empty;

    assign o_head  = mem[rd_ptr[FIFO_PTR_NB-1:0]]; // Show-ahead read

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_push && full) begin
                o_overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_NB-1:0]] <= i_byte;
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_tick,
    input  logic                           i_start,
    input  logic [debug_pkg::NB_DATA_8-1:0] i_data,
    output logic                           o_tx,
    output logic                           o_done
);
    import debug_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t               state;
    logic [TICK_NB-1:0]   tick_cnt;
    logic [BIT_NB-1:0]    bit_cnt;
    logic [NB_DATA_8-1:0] shift_reg;
    logic                 bit_end;

    assign bit_end = i_tick && (tick_cnt == TICK_NB'(OVERSAMPLING - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_tick && state != IDLE) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state    <= START;
                        tick_cnt <= '0;
                        o_tx     <= 1'b0; // Start bit
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_cnt <= '0;
                        o_tx    <= shift_reg[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_NB'(NB_DATA_8 - 1)) begin
                            state <= STOP;
                            o_tx  <= 1'b1;
                        end else begin
                            o_tx  <= shift_reg[1]; // Next bit, shifted on this edge
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_start) begin
            shift_reg <= i_data;
        end else if (state == DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_rx,
    input  logic                i_tick,
    output debug_pkg::rx_byte_t o_byte,
    output logic                o_valid
);
    import debug_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t               state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [TICK_NB-1:0]   tick_cnt;
    logic [BIT_NB-1:0]    bit_cnt;
    logic [NB_DATA_8-1:0] shift_reg;
    logic                 bit_end;
    logic                 mid_start;

    assign bit_end   = i_tick && (tick_cnt == TICK_NB'(OVERSAMPLING - 1));
    assign mid_start = i_tick && (tick_cnt == TICK_NB'(OVERSAMPLING / 2 - 1));

    // Two-flop synchronizer, idle line is high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!rx_sync) begin
                        state    <= START;
                        tick_cnt <= '0;
                    end
                end
                START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? IDLE : DATA; // High at midpoint is a glitch
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_NB'(NB_DATA_8 - 1)) begin
                            state <= STOP;
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1; // Wraps to 0 on bit_end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        o_valid <= 1'b1;
                        state   <= IDLE;
                    end
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == DATA && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[NB_DATA_8-1:1]}; // LSB arrives first
        end
        if (state == STOP && bit_end) begin
            o_byte.data      <= shift_reg;
            o_byte.frame_err <= ~rx_sync;
        end
    end

endmodule

// File: source/baud_gen.sv
`timescale 1ns/1ps

module baud_gen (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_tick
);
    import debug_pkg::*;

    logic [DIV_NB-1:0] div_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_tick  <= 1'b0;
        end else begin
            if (div_cnt == DIV_NB'(TICK_DIV - 1)) begin
                div_cnt <= '0;
                o_tick  <= 1'b1; // One pulse per wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
                o_tick  <= 1'b0;
            end
        end
    end

endmodule

// File: source/debug_pkg.sv
package debug_pkg;

    localparam int NB_DATA_8    = 8;
    localparam int NB_DATA_32   = 32;
    localparam int NB_ADDR      = 5;
    localparam int MEM_DEPTH    = 32;
    localparam int FIFO_DEPTH   = 16;

    localparam int CLK_FREQ     = 45_000_000;
    localparam int BAUD_RATE    = 19200;
    localparam int OVERSAMPLING = 16;
    localparam int TICK_DIV     = CLK_FREQ / (BAUD_RATE * OVERSAMPLING); // 146 cycles

    localparam int DIV_NB       = $clog2(TICK_DIV);     // Baud divider counter width
    localparam int TICK_NB      = $clog2(OVERSAMPLING); // Ticks within one bit
    localparam int BIT_NB       = $clog2(NB_DATA_8);    // Bit index within a byte
    localparam int FIFO_PTR_NB  = $clog2(FIFO_DEPTH);   // FIFO index, wrap bit not included

    localparam logic [NB_DATA_8-1:0] CMD_LOAD  = 8'h4C; // 'L'
    localparam logic [NB_DATA_8-1:0] CMD_READ  = 8'h52; // 'R'
    localparam logic [NB_DATA_8-1:0] CMD_CLEAR = 8'h43; // 'C'

    localparam logic [NB_DATA_8-1:0] RSP_ACK   = 8'h06;
    localparam logic [NB_DATA_8-1:0] RSP_NAK   = 8'h15;

    // Received byte with its framing status
    typedef struct packed {
        logic [NB_DATA_8-1:0] data;
        logic                 frame_err; // Stop bit sampled low
    } rx_byte_t;

    // Instruction memory write request
    typedef struct packed {
        logic [NB_ADDR-1:0]    addr;
        logic [NB_DATA_32-1:0] data;
    } mem_wr_t;

endpackage
